// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_mac_adapt
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: avst_to_axis.sv
// Combinational with no back-pressure; empty is only meaningful on the endofpacket beat, and startofpacket is not needed here.
`timescale 1ns/10ps
`default_nettype none

module avst_to_axis (
    input  wire                    i_avst_valid,
    input  mac_adapt_pkg::data_t   i_avst_data,
    input  wire                    i_avst_endofpacket,
    input  mac_adapt_pkg::empty_t  i_avst_empty,
    input  mac_adapt_pkg::rx_err_t i_avst_error,

    axis_if.source                 axis
);

    localparam mac_adapt_pkg::keep_t KEEP_ALL = '1;

    assign axis.tvalid = i_avst_valid;
    assign axis.tdata  = mac_adapt_pkg::byte_rev(i_avst_data);
    assign axis.tlast  = i_avst_endofpacket;

    // Low KEEP_WIDTH-empty lanes hold data on the end beat.
    assign axis.tkeep = i_avst_endofpacket ? (KEEP_ALL >> i_avst_empty) : KEEP_ALL;

    // All six MAC error causes fold into one flag.
    assign axis.tuser = i_avst_endofpacket & (|i_avst_error);

endmodule

`default_nettype wire

// File: axis_if.sv
// One AXI-Stream beat with a single error bit in tuser; there is no tready, so a beat moves whenever tvalid is high.
`timescale 1ns/10ps
`default_nettype none

interface axis_if;

    mac_adapt_pkg::data_t tdata;
    mac_adapt_pkg::keep_t tkeep;
    logic                 tvalid;
    logic                 tlast;
    logic                 tuser;   // Frame error flag.

    modport source (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tuser
    );

    modport sink (
        input tdata,
        input tkeep,
        input tvalid,
        input tlast,
        input tuser
    );

endinterface

`default_nettype wire

// File: axis_to_avst.sv
// Combinational path with zero latency; tkeep on the last beat must be contiguous from lane 0, and tuser flags an errored frame.
`timescale 1ns/10ps
`default_nettype none

module axis_to_avst (
    input  wire                   i_clk,
    input  wire                   i_rst,

    input  mac_adapt_pkg::data_t  i_axis_tdata,
    input  mac_adapt_pkg::keep_t  i_axis_tkeep,
    input  wire                   i_axis_tvalid,
    input  wire                   i_axis_tlast,
    input  wire                   i_axis_tuser,
    output logic                  o_axis_tready,

    input  wire                   i_avst_ready,
    output logic                  o_avst_valid,
    output mac_adapt_pkg::data_t  o_avst_data,
    output logic                  o_avst_startofpacket,
    output logic                  o_avst_endofpacket,
    output mac_adapt_pkg::empty_t o_avst_empty,
    output logic                  o_avst_error
);

    localparam int CNT_WIDTH = $clog2(mac_adapt_pkg::KEEP_WIDTH + 1);

    logic                 frame_start;   // Next accepted beat opens a frame.
    logic                 beat_accept;
    logic [CNT_WIDTH-1:0] zero_cnt;

    // The MAC sees nothing until the TX side is out of reset.
    assign o_axis_tready = i_avst_ready & ~i_rst;
    assign o_avst_valid  = i_axis_tvalid & ~i_rst;
    assign beat_accept   = i_axis_tvalid & o_axis_tready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            frame_start <= 1'b1;
        end else if (beat_accept) begin
            frame_start <= i_axis_tlast;   // Last beat re-arms, others clear.
        end
    end

    always_comb begin
        zero_cnt = '0;
        for (int k = 0; k < mac_adapt_pkg::KEEP_WIDTH; k++) begin
            zero_cnt = zero_cnt + CNT_WIDTH'(~i_axis_tkeep[k]);
        end
    end

    assign o_avst_data          = mac_adapt_pkg::byte_rev(i_axis_tdata);
    assign o_avst_startofpacket = i_axis_tvalid & frame_start;   // Held with the beat under back-pressure.
    assign o_avst_endofpacket   = i_axis_tlast;

    // Only the final beat may be short.
    assign o_avst_empty = i_axis_tlast ? mac_adapt_pkg::empty_t'(zero_cnt) : '0;
    assign o_avst_error = i_axis_tlast & i_axis_tuser;

endmodule

`default_nettype wire

// File: mac_adapt_pkg.sv
// Widths are fixed for a 64-bit single-channel datapath; changing DATA_WIDTH needs KEEP_WIDTH and EMPTY_WIDTH to follow.
`default_nettype none

package mac_adapt_pkg;

    localparam int DATA_WIDTH   = 64;
    localparam int KEEP_WIDTH   = DATA_WIDTH / 8;
    localparam int EMPTY_WIDTH  = 3;
    localparam int PTP_TS_WIDTH = 96;
    localparam int RX_ERR_WIDTH = 6;

    localparam int RST_SYNC_STAGES_DEFAULT = 4;

    typedef logic [DATA_WIDTH-1:0]   data_t;     // One stream beat.
    typedef logic [KEEP_WIDTH-1:0]   keep_t;     // Byte-lane mask.
    typedef logic [EMPTY_WIDTH-1:0]  empty_t;    // Unused bytes on the final beat.
    typedef logic [PTP_TS_WIDTH-1:0] ptp_ts_t;   // PTP timestamp.
    typedef logic [RX_ERR_WIDTH-1:0] rx_err_t;   // MAC RX error vector.

    // AXI lane k maps to Avalon lane KEEP_WIDTH-1-k in both directions.
    function automatic data_t byte_rev(input data_t d);
        data_t r;
        for (int k = 0; k < KEEP_WIDTH; k++) begin
            r[(KEEP_WIDTH-1-k)*8 +: 8] = d[k*8 +: 8];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: mac_adapt_top.sv
// Single channel on one clock; TX is zero-latency valid/ready, RX has one cycle of latency and no ready.
`timescale 1ns/10ps
`default_nettype none

module mac_adapt_top #(
    parameter int RST_SYNC_STAGES = mac_adapt_pkg::RST_SYNC_STAGES_DEFAULT
) (
    input  wire                            i_clk,
    input  wire                            i_rst,

    // Link status from the MAC.
    input  wire                            i_tx_lanes_stable,
    input  wire                            i_ehip_ready,
    input  wire                            i_rx_pcs_ready,
    output logic                           o_tx_rst,
    output logic                           o_rx_rst,

    // TX user stream.
    input  mac_adapt_pkg::data_t           i_tx_axis_tdata,
    input  mac_adapt_pkg::keep_t           i_tx_axis_tkeep,
    input  wire                            i_tx_axis_tvalid,
    output logic                           o_tx_axis_tready,
    input  wire                            i_tx_axis_tlast,
    input  wire                            i_tx_axis_tuser,

    // TX toward the MAC.
    output logic                           o_avst_tx_valid,
    output mac_adapt_pkg::data_t           o_avst_tx_data,
    output logic                           o_avst_tx_startofpacket,
    output logic                           o_avst_tx_endofpacket,
    output mac_adapt_pkg::empty_t          o_avst_tx_empty,
    output logic                           o_avst_tx_error,
    input  wire                            i_avst_tx_ready,

    // RX from the MAC.
    input  wire                            i_avst_rx_valid,
    input  mac_adapt_pkg::data_t           i_avst_rx_data,
    input  wire                            i_avst_rx_startofpacket,
    input  wire                            i_avst_rx_endofpacket,
    input  mac_adapt_pkg::empty_t          i_avst_rx_empty,
    input  mac_adapt_pkg::rx_err_t         i_avst_rx_error,
    input  mac_adapt_pkg::ptp_ts_t         i_ptp_rx_ts,

    // RX user stream; tuser is {timestamp, error}.
    output mac_adapt_pkg::data_t           o_rx_axis_tdata,
    output mac_adapt_pkg::keep_t           o_rx_axis_tkeep,
    output logic                           o_rx_axis_tvalid,
    output logic                           o_rx_axis_tlast,
    output logic [mac_adapt_pkg::PTP_TS_WIDTH:0] o_rx_axis_tuser
);

    axis_if rx_axis ();

    reset_sync #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_tx_reset_sync (
        .i_clk      (i_clk),
        .i_rst_cond (i_rst | ~i_tx_lanes_stable | ~i_ehip_ready),
        .o_rst      (o_tx_rst)
    );

    reset_sync #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_rx_reset_sync (
        .i_clk      (i_clk),
        .i_rst_cond (i_rst | ~i_rx_pcs_ready),
        .o_rst      (o_rx_rst)
    );

    axis_to_avst u_tx_axis_to_avst (
        .i_clk                (i_clk),
        .i_rst                (o_tx_rst),
        .i_axis_tdata         (i_tx_axis_tdata),
        .i_axis_tkeep         (i_tx_axis_tkeep),
        .i_axis_tvalid        (i_tx_axis_tvalid),
        .i_axis_tlast         (i_tx_axis_tlast),
        .i_axis_tuser         (i_tx_axis_tuser),
        .o_axis_tready        (o_tx_axis_tready),
        .i_avst_ready         (i_avst_tx_ready),
        .o_avst_valid         (o_avst_tx_valid),
        .o_avst_data          (o_avst_tx_data),
        .o_avst_startofpacket (o_avst_tx_startofpacket),
        .o_avst_endofpacket   (o_avst_tx_endofpacket),
        .o_avst_empty         (o_avst_tx_empty),
        .o_avst_error         (o_avst_tx_error)
    );

    // RX startofpacket is redundant, since rx_ts_insert finds frame starts on its own.
    avst_to_axis u_rx_avst_to_axis (
        .i_avst_valid       (i_avst_rx_valid),
        .i_avst_data        (i_avst_rx_data),
        .i_avst_endofpacket (i_avst_rx_endofpacket),
        .i_avst_empty       (i_avst_rx_empty),
        .i_avst_error       (i_avst_rx_error),
        .axis               (rx_axis.source)
    );

    rx_ts_insert u_rx_ts_insert (
        .i_clk         (i_clk),
        .i_rst         (o_rx_rst),
        .i_ptp_ts      (i_ptp_rx_ts),
        .axis          (rx_axis.sink),
        .o_axis_tdata  (o_rx_axis_tdata),
        .o_axis_tkeep  (o_rx_axis_tkeep),
        .o_axis_tvalid (o_rx_axis_tvalid),
        .o_axis_tlast  (o_rx_axis_tlast),
        .o_axis_tuser  (o_rx_axis_tuser)
    );

endmodule

`default_nettype wire

// File: reset_sync.sv
// Condition must be sampled in the i_clk domain; the output releases after RST_SYNC_STAGES clean cycles (needs 2 or more).
`timescale 1ns/10ps
`default_nettype none

module reset_sync #(
    parameter int RST_SYNC_STAGES = mac_adapt_pkg::RST_SYNC_STAGES_DEFAULT
) (
    input  wire  i_clk,
    input  logic i_rst_cond,
    output logic o_rst
);

    logic [RST_SYNC_STAGES-1:0] rst_sr;

    always_ff @(posedge i_clk) begin
        if (i_rst_cond) begin
            rst_sr <= '1;                                       // Hold while asserted.
        end else begin
            rst_sr <= {rst_sr[RST_SYNC_STAGES-2:0], 1'b0};      // Walk zeros toward the output.
        end
    end

    assign o_rst = rst_sr[RST_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: rx_ts_insert.sv
// One cycle of latency and no back-pressure; i_ptp_ts must be valid on the first beat of each frame.
`timescale 1ns/10ps
`default_nettype none

module rx_ts_insert (
    input  wire                            i_clk,
    input  wire                            i_rst,
    input  mac_adapt_pkg::ptp_ts_t         i_ptp_ts,

    axis_if.sink                           axis,

    output mac_adapt_pkg::data_t           o_axis_tdata,
    output mac_adapt_pkg::keep_t           o_axis_tkeep,
    output logic                           o_axis_tvalid,
    output logic                           o_axis_tlast,
    output logic [mac_adapt_pkg::PTP_TS_WIDTH:0] o_axis_tuser
);

    logic                   in_frame;
    mac_adapt_pkg::ptp_ts_t ts_saved;
    mac_adapt_pkg::ptp_ts_t ts_sel;

    // First beat takes the live timestamp.
    assign ts_sel = in_frame ? ts_saved : i_ptp_ts;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_frame      <= 1'b0;
            o_axis_tvalid <= 1'b0;
        end else begin
            o_axis_tvalid <= axis.tvalid;
            if (axis.tvalid) begin
                in_frame <= ~axis.tlast;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (axis.tvalid && !in_frame) begin
            ts_saved <= i_ptp_ts;   // Kept for the rest of the frame.
        end
        o_axis_tdata <= axis.tdata;
        o_axis_tkeep <= axis.tkeep;
        o_axis_tlast <= axis.tlast;
        o_axis_tuser <= {ts_sel, axis.tuser};
    end

endmodule

`default_nettype wire

// File: tb_mac_adapt.sv
// Directed checks for one channel on a 4 ns clock; expects the DUT built with RST_SYNC_STAGES = 4.
`timescale 1ns/10ps
`default_nettype none

module tb_mac_adapt;

    localparam int RST_SYNC_STAGES = 4;
    localparam int TIMEOUT_CYCLES  = 2000;

    logic clk;
    logic i_rst;
    logic i_tx_lanes_stable;
    logic i_ehip_ready;
    logic i_rx_pcs_ready;
    logic o_tx_rst;
    logic o_rx_rst;

    mac_adapt_pkg::data_t    i_tx_axis_tdata;
    mac_adapt_pkg::keep_t    i_tx_axis_tkeep;
    logic                    i_tx_axis_tvalid;
    logic                    o_tx_axis_tready;
    logic                    i_tx_axis_tlast;
    logic                    i_tx_axis_tuser;
    logic                    o_avst_tx_valid;
    mac_adapt_pkg::data_t    o_avst_tx_data;
    logic                    o_avst_tx_startofpacket;
    logic                    o_avst_tx_endofpacket;
    mac_adapt_pkg::empty_t   o_avst_tx_empty;
    logic                    o_avst_tx_error;
    logic                    i_avst_tx_ready;

    logic                    i_avst_rx_valid;
    mac_adapt_pkg::data_t    i_avst_rx_data;
    logic                    i_avst_rx_startofpacket;
    logic                    i_avst_rx_endofpacket;
    mac_adapt_pkg::empty_t   i_avst_rx_empty;
    mac_adapt_pkg::rx_err_t  i_avst_rx_error;
    mac_adapt_pkg::ptp_ts_t  i_ptp_rx_ts;
    mac_adapt_pkg::data_t    o_rx_axis_tdata;
    mac_adapt_pkg::keep_t    o_rx_axis_tkeep;
    logic                    o_rx_axis_tvalid;
    logic                    o_rx_axis_tlast;
    logic [mac_adapt_pkg::PTP_TS_WIDTH:0] o_rx_axis_tuser;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    mac_adapt_top #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) i_dut (
        .i_clk                   (clk),
        .i_rst                   (i_rst),
        .i_tx_lanes_stable       (i_tx_lanes_stable),
        .i_ehip_ready            (i_ehip_ready),
        .i_rx_pcs_ready          (i_rx_pcs_ready),
        .o_tx_rst                (o_tx_rst),
        .o_rx_rst                (o_rx_rst),
        .i_tx_axis_tdata         (i_tx_axis_tdata),
        .i_tx_axis_tkeep         (i_tx_axis_tkeep),
        .i_tx_axis_tvalid        (i_tx_axis_tvalid),
        .o_tx_axis_tready        (o_tx_axis_tready),
        .i_tx_axis_tlast         (i_tx_axis_tlast),
        .i_tx_axis_tuser         (i_tx_axis_tuser),
        .o_avst_tx_valid         (o_avst_tx_valid),
        .o_avst_tx_data          (o_avst_tx_data),
        .o_avst_tx_startofpacket (o_avst_tx_startofpacket),
        .o_avst_tx_endofpacket   (o_avst_tx_endofpacket),
        .o_avst_tx_empty         (o_avst_tx_empty),
        .o_avst_tx_error         (o_avst_tx_error),
        .i_avst_tx_ready         (i_avst_tx_ready),
        .i_avst_rx_valid         (i_avst_rx_valid),
        .i_avst_rx_data          (i_avst_rx_data),
        .i_avst_rx_startofpacket (i_avst_rx_startofpacket),
        .i_avst_rx_endofpacket   (i_avst_rx_endofpacket),
        .i_avst_rx_empty         (i_avst_rx_empty),
        .i_avst_rx_error         (i_avst_rx_error),
        .i_ptp_rx_ts             (i_ptp_rx_ts),
        .o_rx_axis_tdata         (o_rx_axis_tdata),
        .o_rx_axis_tkeep         (o_rx_axis_tkeep),
        .o_rx_axis_tvalid        (o_rx_axis_tvalid),
        .o_rx_axis_tlast         (o_rx_axis_tlast),
        .o_rx_axis_tuser         (o_rx_axis_tuser)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // Inputs change 1 ns after the rising edge; outputs are read at the falling edge.
    task automatic to_drive_point();
        @(posedge clk);
        #1;
    endtask

    // Lane k moves to lane 7-k.
    function automatic mac_adapt_pkg::data_t swap_bytes(input mac_adapt_pkg::data_t d);
        mac_adapt_pkg::data_t r;
        r = {<<8{d}};
        return r;
    endfunction

    function automatic mac_adapt_pkg::data_t random_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic mac_adapt_pkg::ptp_ts_t random_ts();
        return {$random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_resets(input logic tx_exp, input logic rx_exp, input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            check_value("o_tx_rst", 128'(tx_exp), 128'(o_tx_rst));
            check_value("o_rx_rst", 128'(rx_exp), 128'(o_rx_rst));
        end
    endtask

    task automatic check_reset_timing();
        repeat (10) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_resets(1'b1, 1'b1, RST_SYNC_STAGES);
        check_resets(1'b0, 1'b0, 1);
        to_drive_point();
        i_tx_lanes_stable = 1'b0;                 // One-cycle drop on TX only.
        check_resets(1'b0, 1'b0, 1);
        to_drive_point();
        i_tx_lanes_stable = 1'b1;
        check_resets(1'b1, 1'b0, RST_SYNC_STAGES);
        check_resets(1'b0, 1'b0, 1);
        to_drive_point();
    endtask

    task automatic check_tx_outputs(input mac_adapt_pkg::data_t data, input logic last,
                                    input logic sop, input mac_adapt_pkg::empty_t empty,
                                    input logic err);
        check_value("o_avst_tx_valid", 128'(1'b1), 128'(o_avst_tx_valid));
        check_value("o_avst_tx_data", 128'(swap_bytes(data)), 128'(o_avst_tx_data));
        check_value("o_avst_tx_startofpacket", 128'(sop), 128'(o_avst_tx_startofpacket));
        check_value("o_avst_tx_endofpacket", 128'(last), 128'(o_avst_tx_endofpacket));
        check_value("o_avst_tx_empty", 128'(empty), 128'(o_avst_tx_empty));
        check_value("o_avst_tx_error", 128'(err), 128'(o_avst_tx_error));
    endtask

    // Presents one beat, holds it through the stall cycles, then waits for tready.
    task automatic send_tx_beat(input mac_adapt_pkg::keep_t keep, input logic last,
                                input logic user, input logic sop, input int stall);
        mac_adapt_pkg::data_t  data;
        mac_adapt_pkg::empty_t exp_empty;
        logic                  accepted;
        int                    i;
        data = random_data();
        exp_empty = last ? mac_adapt_pkg::empty_t'(8 - $countones(keep)) : '0;
        i_tx_axis_tvalid = 1'b1;
        i_tx_axis_tdata  = data;
        i_tx_axis_tkeep  = keep;
        i_tx_axis_tlast  = last;
        i_tx_axis_tuser  = user;
        i_avst_tx_ready  = (stall == 0);
        for (i = 0; i < stall; i++) begin
            @(negedge clk);
            check_value("o_tx_axis_tready", 128'(1'b0), 128'(o_tx_axis_tready));
            check_tx_outputs(data, last, sop, exp_empty, last & user);
            to_drive_point();
        end
        i_avst_tx_ready = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = (o_tx_axis_tready === 1'b1);
            check_tx_outputs(data, last, sop, exp_empty, last & user);
            to_drive_point();
        end
    endtask

    task automatic send_tx_frame();
        send_tx_beat(8'hFF, 1'b0, 1'b0, 1'b1, 0);
        send_tx_beat(8'hFF, 1'b0, 1'b0, 1'b0, 0);
        send_tx_beat(8'h07, 1'b1, 1'b0, 1'b0, 0);  // Five unused bytes.
        i_tx_axis_tvalid = 1'b0;
    endtask

    task automatic stall_tx_frame();
        send_tx_beat(8'hFF, 1'b0, 1'b0, 1'b1, 4);
        send_tx_beat(8'hFF, 1'b0, 1'b1, 1'b0, 0);  // Error only counts on the last beat.
        send_tx_beat(8'h3F, 1'b1, 1'b1, 1'b0, 0);
        i_tx_axis_tvalid = 1'b1;
        i_tx_axis_tdata  = random_data();
        i_tx_axis_tkeep  = 8'hFF;
        i_tx_axis_tlast  = 1'b0;                   // Mid-frame beat, so only reset re-arms SOP.
        i_tx_axis_tuser  = 1'b0;
        i_ehip_ready     = 1'b0;
        to_drive_point();
        i_ehip_ready = 1'b1;
        check_value("o_tx_rst", 128'(1'b1), 128'(o_tx_rst));
        while (o_tx_rst === 1'b1) begin
            @(negedge clk);
            check_value("o_avst_tx_valid", 128'(1'b0), 128'(o_avst_tx_valid));
            check_value("o_tx_axis_tready", 128'(1'b0), 128'(o_tx_axis_tready));
            to_drive_point();
        end
        @(negedge clk);
        check_value("o_avst_tx_valid", 128'(1'b1), 128'(o_avst_tx_valid));
        check_value("o_avst_tx_startofpacket", 128'(1'b1), 128'(o_avst_tx_startofpacket));
        check_value("o_tx_axis_tready", 128'(1'b1), 128'(o_tx_axis_tready));
        to_drive_point();
        i_tx_axis_tvalid = 1'b0;
    endtask

    // Each output beat is compared one cycle after its input; the timestamp moves every cycle.
    task automatic send_rx_frame(input int beats, input mac_adapt_pkg::empty_t last_empty,
                                 input mac_adapt_pkg::rx_err_t last_err);
        mac_adapt_pkg::data_t   sent_data[8];
        mac_adapt_pkg::ptp_ts_t first_ts;
        mac_adapt_pkg::keep_t   exp_keep;
        logic                   last;
        logic                   exp_err;
        int                     i;
        int                     k;
        first_ts = '0;
        for (i = 0; i <= beats; i++) begin
            i_ptp_rx_ts = random_ts();
            if (i < beats) begin
                last = (i == beats - 1);
                sent_data[i] = random_data();
                if (i == 0) begin
                    first_ts = i_ptp_rx_ts;
                end
                i_avst_rx_valid         = 1'b1;
                i_avst_rx_data          = sent_data[i];
                i_avst_rx_startofpacket = (i == 0);
                i_avst_rx_endofpacket   = last;
                i_avst_rx_empty         = last ? last_empty : '0;
                i_avst_rx_error         = last ? last_err : '0;
            end else begin
                i_avst_rx_valid         = 1'b0;
                i_avst_rx_startofpacket = 1'b0;
                i_avst_rx_endofpacket   = 1'b0;
            end
            @(negedge clk);
            if (i == 0) begin
                check_value("o_rx_axis_tvalid", 128'(1'b0), 128'(o_rx_axis_tvalid));
            end else begin
                last = (i == beats);
                for (k = 0; k < 8; k++) begin
                    exp_keep[k] = !last || (k < 8 - int'(last_empty));
                end
                exp_err = last && (last_err != '0);
                check_value("o_rx_axis_tvalid", 128'(1'b1), 128'(o_rx_axis_tvalid));
                check_value("o_rx_axis_tdata", 128'(swap_bytes(sent_data[i-1])),
                            128'(o_rx_axis_tdata));
                check_value("o_rx_axis_tkeep", 128'(exp_keep), 128'(o_rx_axis_tkeep));
                check_value("o_rx_axis_tlast", 128'(last), 128'(o_rx_axis_tlast));
                check_value("o_rx_axis_tuser", 128'({first_ts, exp_err}), 128'(o_rx_axis_tuser));
            end
            to_drive_point();
        end
        @(negedge clk);
        check_value("o_rx_axis_tvalid", 128'(1'b0), 128'(o_rx_axis_tvalid));
        to_drive_point();
    endtask

    task automatic convert_rx_frame();
        send_rx_frame(2, 3'd3, 6'b000100);   // Keep 0xFF then 0x1F.
    endtask

    task automatic track_rx_timestamps();
        send_rx_frame(3, 3'd0, 6'b000000);
        send_rx_frame(2, 3'd6, 6'b000000);
    endtask

    initial begin
        clk    = 1'b0;
        seed   = 95862;
        errors = 0;
        checks = 0;
        i_rst             = 1'b1;
        i_tx_lanes_stable = 1'b1;
        i_ehip_ready      = 1'b1;
        i_rx_pcs_ready    = 1'b1;
        i_tx_axis_tdata   = '0;
        i_tx_axis_tkeep   = '0;
        i_tx_axis_tvalid  = 1'b0;
        i_tx_axis_tlast   = 1'b0;
        i_tx_axis_tuser   = 1'b0;
        i_avst_tx_ready   = 1'b1;
        i_avst_rx_valid   = 1'b0;
        i_avst_rx_data    = '0;
        i_avst_rx_startofpacket = 1'b0;
        i_avst_rx_endofpacket   = 1'b0;
        i_avst_rx_empty   = '0;
        i_avst_rx_error   = '0;
        i_ptp_rx_ts       = '0;
        check_reset_timing();
        send_tx_frame();
        stall_tx_frame();
        convert_rx_frame();
        track_rx_timestamps();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
mac_adapt_pkg.sv
axis_if.sv
reset_sync.sv
axis_to_avst.sv
avst_to_axis.sv
rx_ts_insert.sv
mac_adapt_top.sv
tb_mac_adapt.sv
